//--- hw/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width of the core
`define LSU_XLEN          64
`define LSU_REG_ADDRWIDTH 5
`define LSU_MEMOP_LEN     4

// memory operation codes where code 0 means no operation
`define LSU_MEMOP_LB  4'd1
`define LSU_MEMOP_LBU 4'd2
`define LSU_MEMOP_LH  4'd3
`define LSU_MEMOP_LHU 4'd4
`define LSU_MEMOP_LW  4'd5
`define LSU_MEMOP_LWU 4'd6
`define LSU_MEMOP_LD  4'd7
`define LSU_MEMOP_SB  4'd8
`define LSU_MEMOP_SH  4'd9
`define LSU_MEMOP_SW  4'd10
`define LSU_MEMOP_SD  4'd11

// size of the data memory in doublewords
`define LSU_MEM_DWORDS 256

`endif

//--- hw/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

  // one memory operation handed over by the core
  typedef struct packed {
    logic [`LSU_MEMOP_LEN-1:0]     mem_op;
    logic [`LSU_XLEN-1:0]          addr;
    logic [`LSU_XLEN-1:0]          store_data;
    logic [`LSU_REG_ADDRWIDTH-1:0] rd_idx;
  } lsu_op_t;

  // answer returned to the core on core_ack
  typedef struct packed {
    logic [`LSU_XLEN-1:0]          load_data;
    logic [`LSU_REG_ADDRWIDTH-1:0] rd_idx;
    logic                          misaligned;
  } lsu_resp_t;

  // one access to the doubleword storage
  // wdata is already placed in its byte lanes and wstrb marks those lanes
  typedef struct packed {
    logic [$clog2(`LSU_MEM_DWORDS)-1:0] dword_idx;
    logic [`LSU_XLEN-1:0]               wdata;
    logic [`LSU_XLEN/8-1:0]             wstrb;
    logic                               write;
  } mem_req_t;

  // full doubleword read back from the storage
  typedef logic [`LSU_XLEN-1:0] mem_rdata_t;

endpackage

//--- hw/dword_ram.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dword_ram (
  input  logic                               clk,
  input  logic                               ram_en,
  input  logic                               ram_we,
  input  logic [$clog2(`LSU_MEM_DWORDS)-1:0] ram_idx,
  input  logic [`LSU_XLEN-1:0]               ram_wdata,
  input  logic [`LSU_XLEN/8-1:0]             ram_wstrb,
  output logic [`LSU_XLEN-1:0]               ram_rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_DWORDS];
  logic [`LSU_XLEN-1:0] merged;

  // current word with the strobed bytes replaced
  always_comb begin
    merged = mem[ram_idx];
    for (int b = 0; b < `LSU_XLEN/8; b++) begin
      if (ram_we && ram_wstrb[b]) begin
        merged[8*b +: 8] = ram_wdata[8*b +: 8];
      end
    end
  end

  // read returns the word as it stands after this cycle's write
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_idx] <= merged;
      end
      ram_rdata <= merged;
    end
  end

endmodule

//--- hw/data_mem_ctrl.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_mem_ctrl import lsu_pkg::*; (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               mem_req,
  input  mem_req_t                           mem_req_data,
  output logic                               mem_ack,
  output mem_rdata_t                         mem_rdata,
  output logic                               ram_en,
  output logic                               ram_we,
  output logic [$clog2(`LSU_MEM_DWORDS)-1:0] ram_idx,
  output logic [`LSU_XLEN-1:0]               ram_wdata,
  output logic [`LSU_XLEN/8-1:0]             ram_wstrb,
  input  logic [`LSU_XLEN-1:0]               ram_rdata
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_READ,
    C_HOLD
  } ctrl_state_e;

  ctrl_state_e state;
  logic        access;

  // a held mem_ack masks mem_req because a request is only taken in idle
  assign access = (state == C_IDLE) & mem_req;

  // the array is enabled in the same cycle the request is first seen
  assign ram_en    = access;
  assign ram_we    = access & mem_req_data.write;
  assign ram_idx   = mem_req_data.dword_idx;
  assign ram_wdata = mem_req_data.wdata;
  assign ram_wstrb = mem_req_data.wstrb;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= C_IDLE;
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
    end else begin
      case (state)
        C_IDLE: begin
          if (access) begin
            state <= C_READ;
          end
        end
        C_READ: begin
          // array output is valid one cycle after the enable
          mem_rdata <= ram_rdata;
          mem_ack   <= 1'b1;
          state     <= C_HOLD;
        end
        C_HOLD: begin
          if (!mem_req) begin
            mem_ack <= 1'b0;
            state   <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_stage import lsu_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       core_req,
  input  lsu_op_t    core_op,
  output logic       core_ack,
  output lsu_resp_t  core_resp,
  output logic       mem_req,
  output mem_req_t   mem_req_data,
  input  logic       mem_ack,
  input  mem_rdata_t mem_rdata
);

  localparam int IDX_W = $clog2(`LSU_MEM_DWORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_RESPOND,
    ST_WAIT_REL
  } state_e;

  state_e  state;
  lsu_op_t op_q;

  logic                 is_byte;
  logic                 is_half;
  logic                 is_word;
  logic                 is_dword;
  logic                 is_store;
  logic                 is_unsigned;
  logic                 misaligned;
  logic [2:0]           lane;
  logic [5:0]           lane_shift;
  logic [7:0]           size_strb;
  logic [`LSU_XLEN-1:0] rd_shifted;
  logic [`LSU_XLEN-1:0] load_ext;

  // the operation is held here for the whole handshake
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && core_req) begin
      op_q <= core_op;
    end
  end

  always_comb begin
    is_byte     = 1'b0;
    is_half     = 1'b0;
    is_word     = 1'b0;
    is_dword    = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    case (op_q.mem_op)
      `LSU_MEMOP_LB:  is_byte = 1'b1;
      `LSU_MEMOP_LBU: begin
        is_byte     = 1'b1;
        is_unsigned = 1'b1;
      end
      `LSU_MEMOP_SB: begin
        is_byte  = 1'b1;
        is_store = 1'b1;
      end
      `LSU_MEMOP_LH:  is_half = 1'b1;
      `LSU_MEMOP_LHU: begin
        is_half     = 1'b1;
        is_unsigned = 1'b1;
      end
      `LSU_MEMOP_SH: begin
        is_half  = 1'b1;
        is_store = 1'b1;
      end
      `LSU_MEMOP_LW:  is_word = 1'b1;
      `LSU_MEMOP_LWU: begin
        is_word     = 1'b1;
        is_unsigned = 1'b1;
      end
      `LSU_MEMOP_SW: begin
        is_word  = 1'b1;
        is_store = 1'b1;
      end
      `LSU_MEMOP_SD: begin
        is_dword = 1'b1;
        is_store = 1'b1;
      end
      // LD and the idle code which never reaches memory
      default: is_dword = 1'b1;
    endcase
  end

  assign lane       = op_q.addr[2:0];
  assign lane_shift = {lane, 3'b000};

  // for natural alignment the low address bits below the access size must be zero
  assign misaligned = (is_half & lane[0]) |
                      (is_word & (lane[1:0] != 2'b00)) |
                      (is_dword & (lane != 3'b000));

  assign size_strb = is_byte ? 8'h01 :
                     is_half ? 8'h03 :
                     is_word ? 8'h0f : 8'hff;

  always_comb begin
    mem_req_data.dword_idx = op_q.addr[IDX_W+2:3];
    mem_req_data.wdata     = op_q.store_data << lane_shift;
    mem_req_data.wstrb     = size_strb << lane;
    mem_req_data.write     = is_store;
  end

  // bring the addressed bytes down to bit 0 before extension
  assign rd_shifted = mem_rdata >> lane_shift;

  always_comb begin
    if (is_byte) begin
      load_ext = {{(`LSU_XLEN-8){~is_unsigned & rd_shifted[7]}}, rd_shifted[7:0]};
    end else if (is_half) begin
      load_ext = {{(`LSU_XLEN-16){~is_unsigned & rd_shifted[15]}}, rd_shifted[15:0]};
    end else if (is_word) begin
      load_ext = {{(`LSU_XLEN-32){~is_unsigned & rd_shifted[31]}}, rd_shifted[31:0]};
    end else begin
      load_ext = rd_shifted;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      core_ack  <= 1'b0;
      core_resp <= '0;
      mem_req   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (core_req) begin
            state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (misaligned) begin
            // answer at once since memory is never touched
            core_ack  <= 1'b1;
            core_resp <= '{load_data: '0, rd_idx: op_q.rd_idx, misaligned: 1'b1};
            state     <= ST_RESPOND;
          end else if (!mem_req) begin
            mem_req <= 1'b1;
          end else if (mem_ack) begin
            mem_req   <= 1'b0;
            core_ack  <= 1'b1;
            core_resp <= '{load_data: is_store ? '0 : load_ext,
                           rd_idx: op_q.rd_idx,
                           misaligned: 1'b0};
            state     <= ST_RESPOND;
          end
        end
        ST_RESPOND: begin
          if (!core_req) begin
            core_ack <= 1'b0;
            state    <= mem_ack ? ST_WAIT_REL : ST_IDLE;
          end
        end
        // the memory side must be back to zero before a new capture
        ST_WAIT_REL: begin
          if (!mem_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top import lsu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      core_req,
  input  lsu_op_t   core_op,
  output logic      core_ack,
  output lsu_resp_t core_resp
);

  logic                               mem_req;
  mem_req_t                           mem_req_data;
  logic                               mem_ack;
  mem_rdata_t                         mem_rdata;
  logic                               ram_en;
  logic                               ram_we;
  logic [$clog2(`LSU_MEM_DWORDS)-1:0] ram_idx;
  logic [`LSU_XLEN-1:0]               ram_wdata;
  logic [`LSU_XLEN/8-1:0]             ram_wstrb;
  logic [`LSU_XLEN-1:0]               ram_rdata;

  mem_stage mem_stage_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .core_req     (core_req),
    .core_op      (core_op),
    .core_ack     (core_ack),
    .core_resp    (core_resp),
    .mem_req      (mem_req),
    .mem_req_data (mem_req_data),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

  data_mem_ctrl data_mem_ctrl_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem_req      (mem_req),
    .mem_req_data (mem_req_data),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_idx      (ram_idx),
    .ram_wdata    (ram_wdata),
    .ram_wstrb    (ram_wstrb),
    .ram_rdata    (ram_rdata)
  );

  dword_ram dword_ram_i (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_idx   (ram_idx),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rdata (ram_rdata)
  );

endmodule

//--- dv/lsu_tb_tasks.svh
task automatic wait_ack(input logic level);
  do begin
    @(posedge clk);
  end while (core_ack !== level);
endtask

// one full four-phase exchange after which the model follows the answer
task automatic do_op(input logic [3:0] op, input logic [63:0] addr,
                     input logic [63:0] data, input logic [4:0] rd);
  lsu_op_t o;
  o = '{mem_op: op, addr: addr, store_data: data, rd_idx: rd};
  @(posedge clk);
  core_op       <= o;
  core_req      <= 1'b1;
  exp_resp      <= expect_resp(o);
  exp_mis       <= (addr % access_bytes(op)) != 0;
  first_pending <= 1'b0;
  wait_ack(1'b1);
  core_req <= 1'b0;
  wait_ack(1'b0);
  update_model(o);
  op_count++;
endtask

task automatic run_directed();
  do_op(`LSU_MEMOP_SD, 64'h100, 64'hfedc_ba98_7654_3210, 5'd1);
  do_op(`LSU_MEMOP_LD, 64'h100, 64'h0, 5'd2);
  // the word lane gets its top bit set while the upper source bits must not land
  do_op(`LSU_MEMOP_SD, 64'h108, 64'h0, 5'd3);
  do_op(`LSU_MEMOP_SW, 64'h10c, 64'hdead_beef_8765_4321, 5'd4);
  do_op(`LSU_MEMOP_LW, 64'h10c, 64'h0, 5'd5);
  do_op(`LSU_MEMOP_LWU, 64'h10c, 64'h0, 5'd6);
  do_op(`LSU_MEMOP_LD, 64'h108, 64'h0, 5'd7);
  do_op(`LSU_MEMOP_SH, 64'h10a, 64'h1234_5678_9abc_c3a5, 5'd8);
  do_op(`LSU_MEMOP_LH, 64'h10a, 64'h0, 5'd9);
  do_op(`LSU_MEMOP_LHU, 64'h10a, 64'h0, 5'd10);
  do_op(`LSU_MEMOP_LD, 64'h108, 64'h0, 5'd11);
  do_op(`LSU_MEMOP_SB, 64'h109, 64'hffff_ffff_ffff_ff9c, 5'd12);
  do_op(`LSU_MEMOP_LB, 64'h109, 64'h0, 5'd13);
  do_op(`LSU_MEMOP_LBU, 64'h109, 64'h0, 5'd14);
  do_op(`LSU_MEMOP_LD, 64'h108, 64'h0, 5'd15);
  do_op(`LSU_MEMOP_SW, 64'h108, 64'h0000_0000_9abc_def0, 5'd16);
  do_op(`LSU_MEMOP_LW, 64'h108, 64'h0, 5'd17);
  // misaligned stores must leave the doubleword alone
  do_op(`LSU_MEMOP_SD, 64'h101, 64'h1111_2222_3333_4444, 5'd18);
  do_op(`LSU_MEMOP_SW, 64'h102, 64'h5555_6666_7777_8888, 5'd19);
  do_op(`LSU_MEMOP_SH, 64'h103, 64'h0000_0000_0000_9999, 5'd20);
  do_op(`LSU_MEMOP_LH, 64'h105, 64'h0, 5'd21);
  do_op(`LSU_MEMOP_LHU, 64'h107, 64'h0, 5'd22);
  do_op(`LSU_MEMOP_LW, 64'h106, 64'h0, 5'd23);
  do_op(`LSU_MEMOP_LWU, 64'h101, 64'h0, 5'd24);
  do_op(`LSU_MEMOP_LD, 64'h104, 64'h0, 5'd25);
  do_op(`LSU_MEMOP_LD, 64'h100, 64'h0, 5'd26);
endtask

task automatic run_random();
  logic [31:0] r_op;
  logic [31:0] r_addr;
  logic [63:0] r_data;
  logic [31:0] r_rd;
  // fill the first 16 doublewords so that every later load hits known bytes
  for (int i = 0; i < 16; i++) begin
    r_data = {$random(seed), $random(seed)};
    do_op(`LSU_MEMOP_SD, 64'(i * 8), r_data, 5'(i));
  end
  for (int n = 0; n < 200; n++) begin
    r_op = $random(seed);
    r_addr = $random(seed);
    r_data = {$random(seed), $random(seed)};
    r_rd = $random(seed);
    do_op(4'(1 + r_op % 11), {57'h0, r_addr[6:0]}, r_data, r_rd[4:0]);
  end
endtask

//--- dv/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int CYCLE_LIMIT = 300 * 8 + 200;

  logic      clk;
  logic      arst_n;
  logic      core_req;
  lsu_op_t   core_op;
  logic      core_ack;
  lsu_resp_t core_resp;

  // expectation for the operation in flight is set together with core_req
  lsu_resp_t exp_resp = '0;
  logic      exp_mis = 1'b0;
  logic      first_pending = 1'b1;

  logic [7:0] ref_mem [`LSU_MEM_DWORDS*8];
  int         errors = 0;
  int         op_count = 0;
  int         cycles = 0;
  integer     seed = 32'h30b8;

  lsu_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .core_req  (core_req),
    .core_op   (core_op),
    .core_ack  (core_ack),
    .core_resp (core_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int access_bytes(input logic [`LSU_MEMOP_LEN-1:0] op);
    case (op)
      `LSU_MEMOP_LB, `LSU_MEMOP_LBU, `LSU_MEMOP_SB: return 1;
      `LSU_MEMOP_LH, `LSU_MEMOP_LHU, `LSU_MEMOP_SH: return 2;
      `LSU_MEMOP_LW, `LSU_MEMOP_LWU, `LSU_MEMOP_SW: return 4;
      default: return 8;
    endcase
  endfunction

  // little-endian read of the model followed by sign or zero fill above the access size
  function automatic lsu_resp_t expect_resp(input lsu_op_t o);
    lsu_resp_t   r;
    int          nbytes;
    logic        is_signed;
    logic [63:0] val;
    nbytes = access_bytes(o.mem_op);
    is_signed = (o.mem_op == `LSU_MEMOP_LB) || (o.mem_op == `LSU_MEMOP_LH) ||
                (o.mem_op == `LSU_MEMOP_LW);
    r.rd_idx = o.rd_idx;
    r.misaligned = (o.addr % nbytes) != 0;
    r.load_data = '0;
    if (!r.misaligned && o.mem_op < `LSU_MEMOP_SB) begin
      val = '0;
      for (int i = 0; i < nbytes; i++) begin
        val[8*i +: 8] = ref_mem[o.addr[10:0] + i];
      end
      if (is_signed && val[8*nbytes-1]) begin
        for (int i = nbytes; i < 8; i++) begin
          val[8*i +: 8] = 8'hff;
        end
      end
      r.load_data = val;
    end
    return r;
  endfunction

  function automatic void update_model(input lsu_op_t o);
    int nbytes;
    nbytes = access_bytes(o.mem_op);
    if (o.mem_op >= `LSU_MEMOP_SB && (o.addr % nbytes) == 0) begin
      for (int i = 0; i < nbytes; i++) begin
        ref_mem[o.addr[10:0] + i] = o.store_data[8*i +: 8];
      end
    end
  endfunction

  `include "lsu_tb_tasks.svh"

  idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
    first_pending |-> !core_ack && core_resp == '0)
    else begin
      errors++;
      $display("** Error at %0t: core_ack expected 0, got %b; core_resp expected 0, got %h",
               $time, $sampled(core_ack), $sampled(core_resp));
    end

  resp_value: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(core_ack) |-> core_resp == exp_resp)
    else begin
      errors++;
      $display("** Error at %0t: core_resp expected %h, got %h",
               $time, $sampled(exp_resp), $sampled(core_resp));
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(core_ack) |-> core_req)
    else begin
      errors++;
      $display("core_ack rose at %0t while core_req was low", $time);
    end

  ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(core_ack) |-> !$past(core_req))
    else begin
      errors++;
      $display("core_ack fell at %0t before core_req was released", $time);
    end

  resp_held: assert property (@(posedge clk) disable iff (!arst_n)
    core_ack && $past(core_ack) |-> $stable(core_resp))
    else begin
      errors++;
      $display("core_resp changed at %0t while core_ack was high", $time);
    end

  aligned_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(core_req) && !exp_mis |-> !core_ack [*5] ##1 core_ack)
    else begin
      errors++;
      $display("core_ack did not rise 4 cycles after capture of an aligned access (%0t)", $time);
    end

  misaligned_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(core_req) && exp_mis |-> !core_ack [*2] ##1 core_ack)
    else begin
      errors++;
      $display("core_ack did not rise 1 cycle after capture of a misaligned access (%0t)", $time);
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("%0d operations, %0d errors", op_count, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    arst_n = 1'b0;
    core_req = 1'b0;
    core_op = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    run_directed();
    run_random();
    repeat (4) @(posedge clk);
    $display("%0d operations, %0d errors", op_count, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
+incdir+dv
hw/lsu_pkg.sv
hw/dword_ram.sv
hw/data_mem_ctrl.sv
hw/mem_stage.sv
hw/lsu_top.sv
dv/lsu_tb.sv
